// File: cossim.f
logic/cossim_pkg.sv
logic/cossim_ctrl.sv
logic/cossim_mac.sv
logic/cossim_ratio.sv
logic/cossim_top.sv
test/cossim_tb.sv

// File: logic/cossim_ctrl.sv
// Row and element loop control
`default_nettype none

module cossim_ctrl import cossim_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [SIZE_W-1:0] size_i,
  input  logic [SIZE_W-1:0] size_j,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              ratio_busy,
  input  logic              res_valid,
  output logic              acc_en,
  output logic              row_last,
  output logic [SIZE_W-1:0] row_idx,
  output logic              busy,
  output logic              done
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  ctrl_state_e state;

  // Sizes of the current run
  logic [SIZE_W-1:0] size_i_q;
  logic [SIZE_W-1:0] size_j_q;

  // Loop indices
  logic [SIZE_W-1:0] elem_cnt;
  logic [SIZE_W-1:0] row_cnt;
  // Results seen so far
  logic [SIZE_W-1:0] res_cnt;

  // Row end transferred in the previous cycle
  logic handoff_q;

  logic xfer;
  logic last_elem;
  logic last_row;
  logic last_res;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign last_elem = (elem_cnt == size_j_q - SIZE_W'(1));
  assign last_row  = (row_cnt == size_i_q - SIZE_W'(1));
  assign last_res  = (res_cnt == size_i_q - SIZE_W'(1));

  // Hold back a row end while the ratio unit cannot take new sums
  // Previous hand-off covers the cycle before ratio_busy rises
  assign in_ready = (state == RUN) && !(last_elem && (ratio_busy || handoff_q));
  assign xfer     = in_valid && in_ready;

  // Accumulator strobes
  assign acc_en   = xfer;
  assign row_last = xfer && last_elem;
  assign row_idx  = row_cnt;

  // Run status
  assign busy = (state != IDLE);
  assign done = (state == DRAIN) && res_valid && last_res;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      size_i_q  <= '0;
      size_j_q  <= '0;
      elem_cnt  <= '0;
      row_cnt   <= '0;
      res_cnt   <= '0;
      handoff_q <= 1'b0;
    end else begin
      handoff_q <= row_last;
      // Results of earlier rows may arrive while still streaming
      if (res_valid) begin
        res_cnt <= res_cnt + SIZE_W'(1);
      end
      case (state)
        IDLE: begin
          if (start) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            elem_cnt <= '0;
            row_cnt  <= '0;
            res_cnt  <= '0;
            state    <= RUN;
          end
        end
        RUN: begin
          if (xfer) begin
            if (last_elem) begin
              // Next row
              elem_cnt <= '0;
              row_cnt  <= row_cnt + SIZE_W'(1);
              if (last_row) begin
                state <= DRAIN;
              end
            end else begin
              elem_cnt <= elem_cnt + SIZE_W'(1);
            end
          end
        end
        DRAIN: begin
          // Wait for the last row's result
          if (done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Results never outnumber the rows handed off
  a_res_after_row: assert property (
    @(posedge CLK) disable iff (RST)
    (state != IDLE) |-> (res_cnt <= row_cnt)
  );

  // Sizes of 1 to 64 only
  a_size_legal: assert property (
    @(posedge CLK) disable iff (RST)
    (state == IDLE && start) |->
      (size_i != '0) && (size_j != '0) && (size_i <= MAX_SIZE) && (size_j <= MAX_SIZE)
  );

endmodule

`default_nettype wire

// File: logic/cossim_mac.sv
// Row multiply-accumulate
`default_nettype none

module cossim_mac import cossim_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  logic              acc_en,
  input  logic              row_last,
  input  logic [SIZE_W-1:0] row_idx,
  input  elem_pair_t        in_pair,
  output accum_t            sums,
  output logic              sums_valid,
  output logic [SIZE_W-1:0] sums_row
);

  //////////////////////////////
  // Products
  //////////////////////////////

  // Signed cross product
  logic signed [2*DATA_W-1:0] prod_ab;
  // Squares, never negative
  logic [2*DATA_W-1:0] sq_a;
  logic [2*DATA_W-1:0] sq_b;

  // Running sums and their next value
  accum_t acc;
  accum_t acc_nxt;

  assign prod_ab = in_pair.a * in_pair.b;
  assign sq_a    = in_pair.a * in_pair.a;
  assign sq_b    = in_pair.b * in_pair.b;

  always_comb begin
    // Dot product extends the sign
    acc_nxt.dot    = acc.dot + ACC_W'(prod_ab);
    acc_nxt.norm_a = acc.norm_a + ACC_W'(sq_a);
    acc_nxt.norm_b = acc.norm_b + ACC_W'(sq_b);
  end

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc        <= '0;
      sums_valid <= 1'b0;
    end else begin
      sums_valid <= acc_en && row_last;
      if (acc_en) begin
        // Row end restarts from zero so the next row can follow at once
        if (row_last) begin
          acc <= '0;
        end else begin
          acc <= acc_nxt;
        end
      end
    end
  end

  // Finished row, held until the next row end
  always_ff @(posedge CLK) begin
    if (acc_en && row_last) begin
      sums     <= acc_nxt;
      sums_row <= row_idx;
    end
  end

endmodule

`default_nettype wire

// File: logic/cossim_pkg.sv
// Cosine similarity shared definitions
`default_nettype none

package cossim_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // One signed matrix element
  localparam int DATA_W = 8;
  // Size inputs, legal range 1 to 64
  localparam int SIZE_W = 7;
  localparam int MAX_SIZE = 64;
  // Row sums, room for 64 products of two 8-bit values
  localparam int ACC_W = 24;

  // Q16 result, 1.0 needs the extra integer bit
  localparam int FRAC_W = 16;
  localparam int RES_W = FRAC_W + 1;
  localparam logic [RES_W-1:0] ONE_Q = 1 << FRAC_W;

  // Divider operands
  localparam int PROD_W = 2 * ACC_W;
  localparam int NUM_W = PROD_W + FRAC_W;
  // One quotient bit per step
  localparam int DIV_STEPS = RES_W;
  localparam int STEP_W = $clog2(DIV_STEPS);
  // Two multiply stages, divide steps, output register
  localparam int RATIO_LAT = 2 + DIV_STEPS + 1;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Matching elements of A and B
  typedef struct packed {
    logic signed [DATA_W-1:0] a;
    logic signed [DATA_W-1:0] b;
  } elem_pair_t;

  // Sums of one row
  typedef struct packed {
    logic signed [ACC_W-1:0] dot;
    logic [ACC_W-1:0]        norm_a;
    logic [ACC_W-1:0]        norm_b;
  } accum_t;

  // One row result
  typedef struct packed {
    logic [RES_W-1:0]  cos2;
    logic              negative;
    logic              zero_norm;
    logic [SIZE_W-1:0] row;
  } result_t;

  // Control FSM
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: logic/cossim_ratio.sv
// Squared cosine ratio unit
`default_nettype none

module cossim_ratio import cossim_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  accum_t            sums,
  input  logic              sums_valid,
  input  logic [SIZE_W-1:0] sums_row,
  output logic              ratio_busy,
  output result_t           res,
  output logic              res_valid
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Multiply stage
  logic [ACC_W-1:0]  dot_mag;
  logic [PROD_W-1:0] dot_sq;
  logic [PROD_W-1:0] norm_prod;
  logic              s1_vld;
  logic              s1_neg;
  logic [SIZE_W-1:0] s1_row;

  // Divider, dot squared times 2^16 over the norm product
  logic [NUM_W-1:0]  num;
  logic [PROD_W-1:0] rem;
  logic [PROD_W-1:0] den;
  // Numerator bits shift out at the top, quotient bits in at the bottom
  logic [RES_W-1:0]  shreg;
  logic [PROD_W:0]   trial;
  logic              q_bit;
  logic              div_zero;
  logic              div_act;
  logic              div_done;
  logic [STEP_W-1:0] step;

  //////////////////////////////
  // Multiply
  //////////////////////////////

  // |dot| is at most 2^20, negation cannot overflow
  assign dot_mag = sums.dot[ACC_W-1] ? ACC_W'(-sums.dot) : ACC_W'(sums.dot);

  always_ff @(posedge CLK) begin
    if (sums_valid) begin
      dot_sq    <= dot_mag * dot_mag;
      norm_prod <= sums.norm_a * sums.norm_b;
      // Sign and row ride along to the output
      s1_neg    <= sums.dot[ACC_W-1];
      s1_row    <= sums_row;
    end
  end

  //////////////////////////////
  // Divide
  //////////////////////////////

  assign num = {dot_sq, {FRAC_W{1'b0}}};

  // Restoring step
  assign trial = {rem, shreg[RES_W-1]};
  assign q_bit = (trial >= {1'b0, den});

  // Step sequencing
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      div_act  <= 1'b0;
      div_done <= 1'b0;
      step     <= '0;
    end else begin
      div_done <= div_act && (step == STEP_W'(DIV_STEPS - 1));
      if (s1_vld) begin
        div_act <= 1'b1;
        step    <= '0;
      end else if (div_act) begin
        step <= step + STEP_W'(1);
        if (step == STEP_W'(DIV_STEPS - 1)) begin
          div_act <= 1'b0;
        end
      end
    end
  end

  // Quotient never exceeds 2^16 by Cauchy-Schwarz
  // so the top part of the numerator starts below den
  always_ff @(posedge CLK) begin
    if (s1_vld) begin
      rem      <= PROD_W'(num[NUM_W-1:RES_W]);
      shreg    <= num[RES_W-1:0];
      den      <= norm_prod;
      div_zero <= (norm_prod == '0);
    end else if (div_act) begin
      rem   <= q_bit ? PROD_W'(trial - {1'b0, den}) : trial[PROD_W-1:0];
      shreg <= {shreg[RES_W-2:0], q_bit};
    end
  end

  //////////////////////////////
  // Output
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_vld     <= 1'b0;
      ratio_busy <= 1'b0;
      res_valid  <= 1'b0;
    end else begin
      s1_vld    <= sums_valid;
      res_valid <= div_done;
      // Busy from accepted sums until the output register loads
      if (sums_valid) begin
        ratio_busy <= 1'b1;
      end else if (div_done) begin
        ratio_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (div_done) begin
      // Zero norm gives no defined ratio, report zero
      res.cos2      <= div_zero ? '0 : shreg;
      res.negative  <= s1_neg;
      res.zero_norm <= div_zero;
      res.row       <= s1_row;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Ctrl stall rule keeps new sums away from a busy divider
  a_no_overlap: assert property (
    @(posedge CLK) disable iff (RST)
    sums_valid |-> !ratio_busy
  );

  // Fixed latency
  a_latency: assert property (
    @(posedge CLK) disable iff (RST)
    sums_valid |-> ##RATIO_LAT res_valid
  );

  // Squared cosine stays within 1.0
  a_bound: assert property (
    @(posedge CLK) disable iff (RST)
    res_valid |-> (res.cos2 <= ONE_Q)
  );

endmodule

`default_nettype wire

// File: logic/cossim_top.sv
// Row-wise cosine similarity top
`default_nettype none

module cossim_top import cossim_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [SIZE_W-1:0] size_i,
  input  logic [SIZE_W-1:0] size_j,
  input  logic              in_valid,
  input  elem_pair_t        in_pair,
  output logic              in_ready,
  output logic              res_valid,
  output result_t           res,
  output logic              busy,
  output logic              done
);

  //////////////////////////////
  // Internal nets
  //////////////////////////////

  // Ctrl to accumulator
  logic              acc_en;
  logic              row_last;
  logic [SIZE_W-1:0] row_idx;

  // Accumulator to ratio unit
  accum_t            sums;
  logic              sums_valid;
  logic [SIZE_W-1:0] sums_row;

  // Ratio unit back to ctrl
  logic              ratio_busy;

  //////////////////////////////
  // Instances
  //////////////////////////////

  // Loop control and stream handshake
  cossim_ctrl u_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_i     (size_i),
    .size_j     (size_j),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .ratio_busy (ratio_busy),
    .res_valid  (res_valid),
    .acc_en     (acc_en),
    .row_last   (row_last),
    .row_idx    (row_idx),
    .busy       (busy),
    .done       (done)
  );

  // Dot product and norms per row
  cossim_mac u_mac (
    .CLK        (CLK),
    .RST        (RST),
    .acc_en     (acc_en),
    .row_last   (row_last),
    .row_idx    (row_idx),
    .in_pair    (in_pair),
    .sums       (sums),
    .sums_valid (sums_valid),
    .sums_row   (sums_row)
  );

  // Squared cosine
  cossim_ratio u_ratio (
    .CLK        (CLK),
    .RST        (RST),
    .sums       (sums),
    .sums_valid (sums_valid),
    .sums_row   (sums_row),
    .ratio_busy (ratio_busy),
    .res        (res),
    .res_valid  (res_valid)
  );

endmodule

`default_nettype wire

// File: test/cossim_tb.sv
// Cosine similarity testbench
`default_nettype none

module cossim_tb import cossim_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  // Fill patterns for one run
  typedef enum int {FILL_RAND, FILL_EQUAL, FILL_NEG, FILL_ZERO_A, FILL_ORTHO} fill_e;

  logic              CLK;
  logic              RST;
  logic              start;
  logic [SIZE_W-1:0] size_i;
  logic [SIZE_W-1:0] size_j;
  logic              in_valid;
  elem_pair_t        in_pair;
  logic              in_ready;
  logic              res_valid;
  result_t           res;
  logic              busy;
  logic              done;

  // Matrices of the current run
  logic signed [DATA_W-1:0] mat_a [MAX_SIZE][MAX_SIZE];
  logic signed [DATA_W-1:0] mat_b [MAX_SIZE][MAX_SIZE];

  // Run list built before reset
  int    run_i[$];
  int    run_j[$];
  fill_e run_fill[$];
  bit    run_gaps[$];

  result_t exp_q[$];
  integer  seed = 24;
  int      budget = 0;
  int      done_cnt = 0;
  int      res_cnt = 0;
  int      stalls = 0;

  cossim_top DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic fail_stop();
    $display("TEST FAILED");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_val(input string name, input longint got, input longint exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // Expected row result from the matrices in wide integer math
  function automatic result_t ref_row(input int r, input int nj);
    longint  dot;
    longint  na;
    longint  nb;
    longint  den;
    result_t exp;
    dot = 0;
    na  = 0;
    nb  = 0;
    for (int k = 0; k < nj; k++) begin
      dot += longint'(mat_a[r][k]) * longint'(mat_b[r][k]);
      na  += longint'(mat_a[r][k]) * longint'(mat_a[r][k]);
      nb  += longint'(mat_b[r][k]) * longint'(mat_b[r][k]);
    end
    den = na * nb;
    exp.row       = SIZE_W'(r);
    exp.negative  = (dot < 0);
    exp.zero_norm = (den == 0);
    // Floor of dot^2 * 2^16 / (na * nb)
    exp.cos2 = (den == 0) ? '0 : RES_W'(((dot * dot) << FRAC_W) / den);
    return exp;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Magnitude 1 to 127 so that negation stays in range
  function automatic logic signed [DATA_W-1:0] nonzero_elem();
    int v;
    v = 1 + ({$random(seed)} % 127);
    if ($random(seed) & 1) begin
      v = -v;
    end
    return DATA_W'(v);
  endfunction

  task automatic fill_matrix(input fill_e fill, input int ni, input int nj);
    for (int r = 0; r < ni; r++) begin
      for (int k = 0; k < nj; k++) begin
        case (fill)
          FILL_EQUAL: begin
            mat_a[r][k] = nonzero_elem();
            mat_b[r][k] = mat_a[r][k];
          end
          FILL_NEG: begin
            mat_a[r][k] = nonzero_elem();
            mat_b[r][k] = -mat_a[r][k];
          end
          FILL_ZERO_A: begin
            mat_a[r][k] = '0;
            mat_b[r][k] = nonzero_elem();
          end
          // A on even columns, B on odd ones
          FILL_ORTHO: begin
            mat_a[r][k] = (k % 2 == 0) ? nonzero_elem() : '0;
            mat_b[r][k] = (k % 2 == 1) ? nonzero_elem() : '0;
          end
          default: begin
            mat_a[r][k] = DATA_W'($random(seed));
            mat_b[r][k] = DATA_W'($random(seed));
          end
        endcase
      end
    end
  endtask

  task automatic add_run(input fill_e fill, input int ni, input int nj, input bit gaps);
    run_fill.push_back(fill);
    run_i.push_back(ni);
    run_j.push_back(nj);
    run_gaps.push_back(gaps);
  endtask

  // One start, the full stream, then wait for done
  task automatic run_matrix(input int n, input int ni, input int nj, input bit gaps);
    int idx;
    for (int r = 0; r < ni; r++) begin
      exp_q.push_back(ref_row(r, nj));
    end
    res_cnt = 0;
    stalls  = 0;
    @(posedge CLK);
    start  <= 1'b1;
    size_i <= SIZE_W'(ni);
    size_j <= SIZE_W'(nj);
    @(posedge CLK);
    start <= 1'b0;
    idx = 0;
    while (idx < ni * nj) begin
      in_valid  <= gaps ? ({$random(seed)} % 3 != 0) : 1'b1;
      in_pair.a <= mat_a[idx / nj][idx % nj];
      in_pair.b <= mat_b[idx / nj][idx % nj];
      @(posedge CLK);
      if (in_valid && in_ready) begin
        idx++;
      end else if (in_valid) begin
        stalls++;
      end
    end
    in_valid <= 1'b0;
    while (done_cnt <= n) @(posedge CLK);
    @(negedge CLK);
    check_val("busy", busy, 0);
    check_val("result count", res_cnt, ni);
    check_val("done count", done_cnt, n + 1);
    // Short rows with no gaps must hit the hand-off stall
    if (!gaps && nj < RATIO_LAT + 1 && ni > 1) begin
      check_val("in_ready stall seen", stalls > 0, 1);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST      = 1'b1;
    start    = 1'b0;
    size_i   = '0;
    size_j   = '0;
    in_valid = 1'b0;
    in_pair  = '0;
    add_run(FILL_EQUAL, 1, 2 + {$random(seed)} % 63, 1'b0);
    add_run(FILL_NEG, 1, 2 + {$random(seed)} % 63, 1'b1);
    add_run(FILL_ZERO_A, 1, 2 + {$random(seed)} % 63, 1'b0);
    add_run(FILL_ORTHO, 1, 2 + {$random(seed)} % 63, 1'b1);
    add_run(FILL_RAND, 2 + {$random(seed)} % 7, 1 + {$random(seed)} % 20, 1'b0);
    add_run(FILL_RAND, 6, 3, 1'b0);
    for (int n = 0; n < 6; n++) begin
      add_run(FILL_RAND, 1 + {$random(seed)} % 64, 1 + {$random(seed)} % 64, n[0]);
    end
    // Twice the pairs plus 30 cycles per row
    foreach (run_i[n]) begin
      budget += 2 * (run_i[n] * run_j[n] + 30 * run_i[n]);
    end
    budget += 40;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    repeat (3) @(negedge CLK);
    check_val("in_ready", in_ready, 0);
    check_val("res_valid", res_valid, 0);
    check_val("busy", busy, 0);
    check_val("done", done, 0);
    foreach (run_i[n]) begin
      fill_matrix(run_fill[n], run_i[n], run_j[n]);
      run_matrix(n, run_i[n], run_j[n], run_gaps[n]);
    end
    repeat (5) @(posedge CLK);
    if (exp_q.size() == 0 && done_cnt == run_i.size()) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("Error: results or done pulses missing at the end of the run");
      fail_stop();
    end
  end

  //////////////////////////////
  // Result comparison
  //////////////////////////////

  always @(negedge CLK) begin
    result_t exp;
    if (!RST) begin
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0d ns: result arrived with no row expected", $time);
          fail_stop();
        end
        exp = exp_q.pop_front();
        check_val("res.row", res.row, exp.row);
        check_val("res.cos2", res.cos2, exp.cos2);
        check_val("res.negative", res.negative, exp.negative);
        check_val("res.zero_norm", res.zero_norm, exp.zero_norm);
        // Run still active while its results come out
        check_val("busy", busy, 1);
        // Done only with the last row of the run
        check_val("done", done, exp_q.size() == 0);
        res_cnt++;
      end else begin
        check_val("done", done, 0);
      end
      if (done) done_cnt++;
    end
  end

  // Watchdog
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge CLK);
    $display("Error: watchdog expired, the DUT stopped producing results");
    fail_stop();
  end

endmodule

`default_nettype wire
